/* compile.f */
+incdir+dv
common/dvi_pkg.sv
hw/test_pattern_gen.sv
hw/dvi_tx/dvi_timing.sv
hw/dvi_tx/tmds_encoder.sv
hw/dvi_tx/dvi_tx_parallel.sv
hw/video_out_core.sv
dv/tb_video_out_core.sv

/* Bender.yml */
package:
  name: video_out_core

sources:
  # Package first, then leaf blocks, then the top level
  - files:
      - common/dvi_pkg.sv
      - hw/test_pattern_gen.sv
      - hw/dvi_tx/dvi_timing.sv
      - hw/dvi_tx/tmds_encoder.sv
      - hw/dvi_tx/dvi_tx_parallel.sv
      - hw/video_out_core.sv

  # Testbench with its included check header
  - target: test
    include_dirs:
      - dv
    files:
      - dv/tb_video_out_core.sv

/* dv/video_out_checks.svh */
`ifndef VIDEO_OUT_CHECKS_SVH
`define VIDEO_OUT_CHECKS_SVH

// ----------------------------------------
// Reference TMDS model

int ref_disp [3]; // Running disparity per channel, ch0 to ch2

function automatic void clear_ref_disparity();
	for (int c = 0; c < 3; c++) begin
		ref_disp[c] = 0;
	end
endfunction

// 8b/10b data symbol, updates the channel's disparity
function automatic logic [W_TMDS-1:0] ref_encode(input logic [W_COLOUR-1:0] d, input int ch);
	int          n1_d;
	int          n1_q;
	int          n0_q;
	logic        xnor_mode;
	logic [8:0]  q_m;
	logic [9:0]  sym;
	n1_d = 0;
	for (int i = 0; i < 8; i++) begin
		n1_d = n1_d + int'(d[i]);
	end
	xnor_mode = (n1_d > 4) || (n1_d == 4 && d[0] == 1'b0);
	q_m[0] = d[0];
	for (int i = 1; i < 8; i++) begin
		q_m[i] = xnor_mode ? !(q_m[i-1] ^ d[i]) : (q_m[i-1] ^ d[i]);
	end
	q_m[8] = !xnor_mode;
	n1_q = 0;
	for (int i = 0; i < 8; i++) begin
		n1_q = n1_q + int'(q_m[i]);
	end
	n0_q = 8 - n1_q;
	if (ref_disp[ch] == 0 || n1_q == n0_q) begin
		sym = {!q_m[8], q_m[8], q_m[8] ? q_m[7:0] : ~q_m[7:0]};
		ref_disp[ch] += q_m[8] ? (n1_q - n0_q) : (n0_q - n1_q);
	end else if ((ref_disp[ch] > 0 && n1_q > n0_q) || (ref_disp[ch] < 0 && n0_q > n1_q)) begin
		sym = {1'b1, q_m[8], ~q_m[7:0]}; // Invert to pull back toward zero
		ref_disp[ch] += 2 * int'(q_m[8]) + (n0_q - n1_q);
	end else begin
		sym = {1'b0, q_m[8], q_m[7:0]};
		ref_disp[ch] += (n1_q - n0_q) - 2 * int'(!q_m[8]);
	end
	return sym;
endfunction

// Control symbol for {c1, c0}
function automatic logic [W_TMDS-1:0] control_symbol(input logic c1, input logic c0);
	case ({c1, c0})
		2'b00:   return TMDS_CTRL_00;
		2'b01:   return TMDS_CTRL_01;
		2'b10:   return TMDS_CTRL_10;
		default: return TMDS_CTRL_11;
	endcase
endfunction

function automatic rgb_t pattern_rgb(input int h, input int v, input int frame);
	rgb_t pix;
	pix.r = W_COLOUR'(((h + frame) * 4) % 256);
	pix.g = W_COLOUR'(((v + frame) * 4) % 256);
	pix.b = W_COLOUR'(frame);
	return pix;
endfunction

function automatic tmds_t idle_tmds();
	return '{ch2: TMDS_CTRL_00, ch1: TMDS_CTRL_00, ch0: TMDS_CTRL_11};
endfunction

// Symbols expected for one raster position
function automatic tmds_t expected_tmds(input int h, input int v, input int frame);
	tmds_t exp;
	rgb_t  pix;
	logic  hs;
	logic  vs;
	int    h_sync_start;
	int    v_sync_start;
	h_sync_start = H_ACTIVE_PIXELS + H_FRONT_PORCH;
	v_sync_start = V_ACTIVE_LINES + V_FRONT_PORCH;
	hs = (h >= h_sync_start && h < h_sync_start + H_SYNC_WIDTH) ? H_SYNC_POLARITY
		: !H_SYNC_POLARITY;
	vs = (v >= v_sync_start && v < v_sync_start + V_SYNC_WIDTH) ? V_SYNC_POLARITY
		: !V_SYNC_POLARITY;
	if (h < H_ACTIVE_PIXELS && v < V_ACTIVE_LINES) begin
		pix = pattern_rgb(h, v, frame);
		exp.ch2 = ref_encode(pix.r, 2);
		exp.ch1 = ref_encode(pix.g, 1);
		exp.ch0 = ref_encode(pix.b, 0);
	end else begin
		clear_ref_disparity(); // Blanking restarts the balance
		exp.ch2 = TMDS_CTRL_00;
		exp.ch1 = TMDS_CTRL_00;
		exp.ch0 = control_symbol(vs, hs);
	end
	return exp;
endfunction

// ----------------------------------------
// Compare tasks

task automatic check_tmds(input string name, input tmds_t exp, input tmds_t act);
	if (act !== exp) begin
		stop_on_error($sformatf("Mismatch at %0t: %s expected %h, actual %h",
			$time, name, exp, act));
	end
endtask

task automatic check_symbol(input string name, input logic [W_TMDS-1:0] exp,
	input logic [W_TMDS-1:0] act);
	if (act !== exp) begin
		stop_on_error($sformatf("Mismatch at %0t: %s expected %b, actual %b",
			$time, name, exp, act));
	end
endtask

`endif

/* dv/tb_video_out_core.sv */
`timescale 1ns/10ps

module tb_video_out_core;

	import dvi_pkg::*;

	localparam int CLK_HALF     = 50;
	localparam int RESET_CYCLES = 16;
	localparam int RANDOM_LINES = 4;
	localparam int WAIT_LIMIT   = 2 * H_TOTAL * V_TOTAL;

	logic  clk_dvi_pix;
	logic  rst_n_dvi_pix;
	tmds_t o_tmds;

	// Raster position whose symbol sits on o_tmds
	int h_pos;
	int v_pos;
	int frame_pos;

	video_out_core video_out_core_inst (
		.clk_dvi_pix   (clk_dvi_pix),
		.rst_n_dvi_pix (rst_n_dvi_pix),
		.o_tmds        (o_tmds)
	);

	initial begin
		clk_dvi_pix = 1'b0;
		forever #CLK_HALF clk_dvi_pix = ~clk_dvi_pix;
	end

	task automatic stop_on_error(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped on first error");
	endtask

	`include "video_out_checks.svh"

	// ----------------------------------------
	// Raster tracking

	task automatic next_symbol();
		@(negedge clk_dvi_pix); // Away from the launching edge
		h_pos++;
		if (h_pos == H_TOTAL) begin
			h_pos = 0;
			v_pos++;
			if (v_pos == V_TOTAL) begin
				v_pos = 0;
				frame_pos++;
			end
		end
	endtask

	task automatic wait_for_line(input int line, input int frame);
		int n;
		n = 0;
		while (!(h_pos == 0 && v_pos == line && frame_pos == frame)) begin
			if (n == WAIT_LIMIT) begin
				stop_on_error($sformatf("Timeout waiting for line %0d of frame %0d", line, frame));
			end else begin
				next_symbol();
				n++;
			end
		end
	endtask

	task automatic check_current();
		tmds_t exp;
		exp = expected_tmds(h_pos, v_pos, frame_pos);
		if (h_pos < H_ACTIVE_PIXELS && v_pos < V_ACTIVE_LINES) begin
			check_symbol("o_tmds.ch2", exp.ch2, o_tmds.ch2);
			check_symbol("o_tmds.ch1", exp.ch1, o_tmds.ch1);
			check_symbol("o_tmds.ch0", exp.ch0, o_tmds.ch0);
		end else begin
			check_tmds("o_tmds", exp, o_tmds);
		end
	endtask

	// ----------------------------------------
	// Directed tests

	task automatic test_reset();
		for (int i = 0; i < RESET_CYCLES; i++) begin
			@(negedge clk_dvi_pix);
			check_tmds("o_tmds", idle_tmds(), o_tmds);
			@(posedge clk_dvi_pix);
		end
		rst_n_dvi_pix <= 1'b1;
		@(negedge clk_dvi_pix); // Encoders not clocked yet since release
		check_tmds("o_tmds", idle_tmds(), o_tmds);
		clear_ref_disparity();
		next_symbol();
	endtask

	task automatic test_first_line();
		wait_for_line(0, 0);
		clear_ref_disparity();
		for (int h = 0; h < H_ACTIVE_PIXELS; h++) begin
			check_current();
			next_symbol();
		end
	endtask

	task automatic test_hblank();
		for (int h = H_ACTIVE_PIXELS; h < H_TOTAL; h++) begin
			check_current();
			next_symbol();
		end
	endtask

	task automatic test_vblank();
		wait_for_line(V_ACTIVE_LINES, 0);
		for (int n = 0; n < (V_TOTAL - V_ACTIVE_LINES) * H_TOTAL; n++) begin
			check_current();
			next_symbol();
		end
	endtask

	// One random line per band, so lines come in raster order
	task automatic test_random_lines(input int frame, input int first_line);
		int span;
		int line;
		span = (V_ACTIVE_LINES - first_line) / RANDOM_LINES;
		for (int k = 0; k < RANDOM_LINES; k++) begin
			line = first_line + k * span + int'($urandom % span);
			wait_for_line(line, frame);
			clear_ref_disparity();
			for (int h = 0; h < H_ACTIVE_PIXELS; h++) begin
				check_current();
				next_symbol();
			end
		end
	endtask

	initial begin
		rst_n_dvi_pix = 1'b0;
		h_pos         = -1; // Reset value is shown first
		v_pos         = 0;
		frame_pos     = 0;
		void'($urandom(87));
		test_reset();
		test_first_line();
		test_hblank();
		test_random_lines(0, 1);
		test_vblank();
		test_random_lines(1, 0); // Pattern must have moved on by one frame
		$display("TEST PASSED");
		$finish;
	end

endmodule

/* hw/video_out_core.sv */
`timescale 1ns/10ps

module video_out_core (
	input  logic           clk_dvi_pix,
	input  logic           rst_n_dvi_pix,
	output dvi_pkg::tmds_t o_tmds
);

	import dvi_pkg::*;

	// ----------------------------------------
	// Pattern source to transmitter

	rgb_t rgb;
	logic rgb_rdy; // Level, high on active pixels

	test_pattern_gen pattern_inst (
		.clk_dvi_pix   (clk_dvi_pix),
		.rst_n_dvi_pix (rst_n_dvi_pix),
		.i_rgb_rdy     (rgb_rdy),
		.o_rgb         (rgb)
	);

	// Symbols leave one cycle after their pixel
	dvi_tx_parallel dvi_tx_inst (
		.clk_dvi_pix   (clk_dvi_pix),
		.rst_n_dvi_pix (rst_n_dvi_pix),
		.i_rgb         (rgb),
		.o_rgb_rdy     (rgb_rdy),
		.o_tmds        (o_tmds)
	);

endmodule

/* hw/dvi_tx/dvi_tx_parallel.sv */
`timescale 1ns/10ps

module dvi_tx_parallel (
	input  logic           clk_dvi_pix,
	input  logic           rst_n_dvi_pix,
	input  dvi_pkg::rgb_t  i_rgb,
	output logic           o_rgb_rdy,
	output dvi_pkg::tmds_t o_tmds
);

	import dvi_pkg::*;

	sync_t             sync;
	logic [W_TMDS-1:0] sym0;
	logic [W_TMDS-1:0] sym1;
	logic [W_TMDS-1:0] sym2;

	dvi_timing timing_inst (
		.clk_dvi_pix   (clk_dvi_pix),
		.rst_n_dvi_pix (rst_n_dvi_pix),
		.o_sync        (sync)
	);

	assign o_rgb_rdy = sync.den; // Pixel taken on every active cycle

	// ----------------------------------------
	// Channel encoders, syncs ride on blue

	tmds_encoder #(
		.IDLE_CTRL (2'b11) // Both syncs inactive
	) enc0 (
		.clk_dvi_pix   (clk_dvi_pix),
		.rst_n_dvi_pix (rst_n_dvi_pix),
		.i_data        (i_rgb.b),
		.i_ctrl        ({sync.vsync, sync.hsync}),
		.i_den         (sync.den),
		.o_symbol      (sym0)
	);

	tmds_encoder enc1 (
		.clk_dvi_pix   (clk_dvi_pix),
		.rst_n_dvi_pix (rst_n_dvi_pix),
		.i_data        (i_rgb.g),
		.i_ctrl        (2'b00),
		.i_den         (sync.den),
		.o_symbol      (sym1)
	);

	tmds_encoder enc2 (
		.clk_dvi_pix   (clk_dvi_pix),
		.rst_n_dvi_pix (rst_n_dvi_pix),
		.i_data        (i_rgb.r),
		.i_ctrl        (2'b00),
		.i_den         (sync.den),
		.o_symbol      (sym2)
	);

	assign o_tmds = '{ch2: sym2, ch1: sym1, ch0: sym0};

endmodule

/* hw/dvi_tx/tmds_encoder.sv */
`timescale 1ns/10ps

module tmds_encoder #(
	parameter logic [1:0] IDLE_CTRL = 2'b00 // Control pair shown while in reset
) (
	input  logic                         clk_dvi_pix,
	input  logic                         rst_n_dvi_pix,
	input  logic [dvi_pkg::W_COLOUR-1:0] i_data,
	input  logic [1:0]                   i_ctrl,
	input  logic                         i_den,
	output logic [dvi_pkg::W_TMDS-1:0]   o_symbol
);

	import dvi_pkg::*;

	logic [3:0]          n1_data;
	logic                use_xnor;
	logic [W_COLOUR:0]   q_m;      // Bit 8 flags XOR (1) or XNOR (0)
	logic [3:0]          n1_qm;
	logic signed [4:0]   diff_qm;  // Ones minus zeros over q_m[7:0]

	logic signed [4:0]   disp_q;
	logic signed [4:0]   disp_d;
	logic [W_TMDS-1:0]   symbol_d;

	// ----------------------------------------
	// Stage 1, transition minimising

	always_comb begin
		n1_data = '0;
		for (int i = 0; i < W_COLOUR; i++) begin
			n1_data = n1_data + 4'(i_data[i]);
		end
		use_xnor = (n1_data > 4'd4) || (n1_data == 4'd4 && !i_data[0]);

		q_m[0] = i_data[0];
		for (int i = 1; i < W_COLOUR; i++) begin
			q_m[i] = use_xnor ? ~(q_m[i-1] ^ i_data[i]) : (q_m[i-1] ^ i_data[i]);
		end
		q_m[W_COLOUR] = ~use_xnor;

		n1_qm = '0;
		for (int i = 0; i < W_COLOUR; i++) begin
			n1_qm = n1_qm + 4'(q_m[i]);
		end
		diff_qm = 5'(signed'({1'b0, n1_qm, 1'b0}) - 6'sd8); // 2*n1 - 8
	end

	// ----------------------------------------
	// Stage 2, DC balance

	always_comb begin
		if (!i_den) begin
			symbol_d = tmds_ctrl_symbol(i_ctrl);
			disp_d   = '0;                          // Blanking restarts the balance
		end else if (disp_q == 5'sd0 || diff_qm == 5'sd0) begin
			// No bias either way, bit 9 records the choice
			symbol_d = {~q_m[8], q_m[8], q_m[8] ? q_m[7:0] : ~q_m[7:0]};
			disp_d   = q_m[8] ? disp_q + diff_qm : disp_q - diff_qm;
		end else if (disp_q[4] == diff_qm[4]) begin
			// Word would push further the same way, so invert
			symbol_d = {1'b1, q_m[8], ~q_m[7:0]};
			disp_d   = disp_q + (q_m[8] ? 5'sd2 : 5'sd0) - diff_qm;
		end else begin
			symbol_d = {1'b0, q_m[8], q_m[7:0]};
			disp_d   = disp_q - (q_m[8] ? 5'sd0 : 5'sd2) + diff_qm;
		end
	end

	always_ff @(posedge clk_dvi_pix or negedge rst_n_dvi_pix) begin
		if (!rst_n_dvi_pix) begin
			o_symbol <= tmds_ctrl_symbol(IDLE_CTRL);
			disp_q   <= '0;
		end else begin
			o_symbol <= symbol_d;
			disp_q   <= disp_d;
		end
	end

	// ----------------------------------------
	// Checks

	a_disp_bounded: assert property (
		@(posedge clk_dvi_pix) disable iff (!rst_n_dvi_pix)
		(disp_q >= -5'sd8) && (disp_q <= 5'sd8)
	) else $error("running disparity out of range: %0d", disp_q);

endmodule

/* hw/dvi_tx/dvi_timing.sv */
`timescale 1ns/10ps

module dvi_timing (
	input  logic           clk_dvi_pix,
	input  logic           rst_n_dvi_pix,
	output dvi_pkg::sync_t o_sync
);

	import dvi_pkg::*;

	logic [W_CTR-1:0] h_ctr;
	logic [W_CTR-1:0] v_ctr;

	logic h_wrap;
	logic v_wrap;

	logic h_active;
	logic v_active;
	logic h_in_sync;
	logic v_in_sync;

	// ----------------------------------------
	// Raster counters, free running

	assign h_wrap = h_ctr == W_CTR'(H_TOTAL - 1);
	assign v_wrap = v_ctr == W_CTR'(V_TOTAL - 1);

	always_ff @(posedge clk_dvi_pix or negedge rst_n_dvi_pix) begin
		if (!rst_n_dvi_pix) begin
			h_ctr <= '0;
		end else if (h_wrap) begin
			h_ctr <= '0;
		end else begin
			h_ctr <= h_ctr + 1'b1;
		end
	end

	// Line count steps once per full line
	always_ff @(posedge clk_dvi_pix or negedge rst_n_dvi_pix) begin
		if (!rst_n_dvi_pix) begin
			v_ctr <= '0;
		end else if (h_wrap) begin
			if (v_wrap) begin
				v_ctr <= '0;
			end else begin
				v_ctr <= v_ctr + 1'b1;
			end
		end
	end

	// ----------------------------------------
	// Region decode

	// Active region comes first in each line and frame
	assign h_active = h_ctr < W_CTR'(H_ACTIVE_PIXELS);
	assign v_active = v_ctr < W_CTR'(V_ACTIVE_LINES);

	// Sync sits between front and back porch
	assign h_in_sync = (h_ctr >= W_CTR'(H_SYNC_START)) && (h_ctr < W_CTR'(H_SYNC_END));
	assign v_in_sync = (v_ctr >= W_CTR'(V_SYNC_START)) && (v_ctr < W_CTR'(V_SYNC_END));

	always_comb begin
		o_sync.hsync = h_in_sync ? H_SYNC_POLARITY : ~H_SYNC_POLARITY;
		o_sync.vsync = v_in_sync ? V_SYNC_POLARITY : ~V_SYNC_POLARITY;
		o_sync.den   = h_active && v_active;
	end

	// ----------------------------------------
	// Checks

	a_den_outside_sync: assert property (
		@(posedge clk_dvi_pix) disable iff (!rst_n_dvi_pix)
		o_sync.den |-> (o_sync.hsync != H_SYNC_POLARITY) && (o_sync.vsync != V_SYNC_POLARITY)
	) else $error("data enable overlaps a sync pulse");

endmodule

/* hw/test_pattern_gen.sv */
`timescale 1ns/10ps

module test_pattern_gen (
	input  logic          clk_dvi_pix,
	input  logic          rst_n_dvi_pix,
	input  logic          i_rgb_rdy,
	output dvi_pkg::rgb_t o_rgb
);

	import dvi_pkg::*;

	logic [W_CTR-1:0] h_ctr;
	logic [W_CTR-1:0] v_ctr;
	logic [W_CTR-1:0] frame_ctr;

	logic h_last;
	logic v_last;

	assign h_last = h_ctr == W_CTR'(H_ACTIVE_PIXELS - 1);
	assign v_last = v_ctr == W_CTR'(V_ACTIVE_LINES - 1);

	// ----------------------------------------
	// Position within the visible picture

	always_ff @(posedge clk_dvi_pix or negedge rst_n_dvi_pix) begin
		if (!rst_n_dvi_pix) begin
			h_ctr     <= '0;
			v_ctr     <= '0;
			frame_ctr <= '0;
		end else if (i_rgb_rdy) begin // Only step on pixels actually taken
			if (h_last) begin
				h_ctr <= '0;
				if (v_last) begin
					v_ctr     <= '0;
					frame_ctr <= frame_ctr + 1'b1; // Moves the pattern
				end else begin
					v_ctr <= v_ctr + 1'b1;
				end
			end else begin
				h_ctr <= h_ctr + 1'b1;
			end
		end
	end

	// Gradients scroll with the frame count, low bits kept
	always_comb begin
		o_rgb.r = W_COLOUR'((h_ctr + frame_ctr) << 2);
		o_rgb.g = W_COLOUR'((v_ctr + frame_ctr) << 2);
		o_rgb.b = W_COLOUR'(frame_ctr);
	end

	// ----------------------------------------
	// Checks

	a_h_in_range: assert property (
		@(posedge clk_dvi_pix) disable iff (!rst_n_dvi_pix)
		h_ctr <= W_CTR'(H_ACTIVE_PIXELS - 1)
	) else $error("pattern pixel counter past end of line");

endmodule

/* common/dvi_pkg.sv */
package dvi_pkg;

	// ----------------------------------------
	// 640x480p60 raster timing

	localparam int H_ACTIVE_PIXELS = 640;
	localparam int H_FRONT_PORCH   = 16;
	localparam int H_SYNC_WIDTH    = 96;
	localparam int H_BACK_PORCH    = 48;
	localparam int H_TOTAL         = H_ACTIVE_PIXELS + H_FRONT_PORCH
		+ H_SYNC_WIDTH + H_BACK_PORCH;

	localparam int V_ACTIVE_LINES = 480;
	localparam int V_FRONT_PORCH  = 10;
	localparam int V_SYNC_WIDTH   = 2;
	localparam int V_BACK_PORCH   = 33;
	localparam int V_TOTAL        = V_ACTIVE_LINES + V_FRONT_PORCH
		+ V_SYNC_WIDTH + V_BACK_PORCH;

	// Sync windows, end is exclusive
	localparam int H_SYNC_START = H_ACTIVE_PIXELS + H_FRONT_PORCH;
	localparam int H_SYNC_END   = H_SYNC_START + H_SYNC_WIDTH;
	localparam int V_SYNC_START = V_ACTIVE_LINES + V_FRONT_PORCH;
	localparam int V_SYNC_END   = V_SYNC_START + V_SYNC_WIDTH;

	localparam logic H_SYNC_POLARITY = 1'b0; // Active low
	localparam logic V_SYNC_POLARITY = 1'b0;

	// ----------------------------------------
	// Widths and TMDS control symbols

	localparam int W_COLOUR = 8;
	localparam int W_TMDS   = 10;
	localparam int W_CTR    = 11;

	localparam logic [W_TMDS-1:0] TMDS_CTRL_00 = 10'b1101010100;
	localparam logic [W_TMDS-1:0] TMDS_CTRL_01 = 10'b0010101011;
	localparam logic [W_TMDS-1:0] TMDS_CTRL_10 = 10'b0101010100;
	localparam logic [W_TMDS-1:0] TMDS_CTRL_11 = 10'b1010101011;

	typedef struct packed {
		logic [W_COLOUR-1:0] r;
		logic [W_COLOUR-1:0] g;
		logic [W_COLOUR-1:0] b;
	} rgb_t;

	typedef struct packed {
		logic hsync; // Line level, polarity applied
		logic vsync;
		logic den;   // High in the active region
	} sync_t;

	typedef struct packed {
		logic [W_TMDS-1:0] ch2;
		logic [W_TMDS-1:0] ch1;
		logic [W_TMDS-1:0] ch0;
	} tmds_t;

	// Control symbol for {c1, c0}
	function automatic logic [W_TMDS-1:0] tmds_ctrl_symbol(input logic [1:0] ctrl);
		case (ctrl)
			2'b00:   return TMDS_CTRL_00;
			2'b01:   return TMDS_CTRL_01;
			2'b10:   return TMDS_CTRL_10;
			default: return TMDS_CTRL_11;
		endcase
	endfunction

endpackage
